/* include/c64_loader_macros.svh */
// C64 file loader constants for download kinds, memory regions and cartridge layout
`ifndef C64_LOADER_MACROS_SVH
`define C64_LOADER_MACROS_SVH

// ==============================
// Widths
// ==============================
`define LD_ADDR_W 25

// Download indices as sent by the host
`define LD_IDX_PRG     8'h04
`define LD_IDX_CRT     8'h05
`define LD_IDX_CRT_ALT 8'hc0
`define LD_IDX_TAP     8'h06

// ==============================
// Memory map
// ==============================
`define LD_CRT_BASE 'h100000
`define LD_TAP_BASE 'h200000

`define LD_CRT_PAYLOAD_START 'h40 // First chip header follows the file header
`define LD_CRT_ALIGN_BITS    13   // Chips start on 8 KB boundaries
`define LD_CRT_CHIP_HDR_LEN  16   // Counted in the block length field

`define LD_ZP_END 'h100 // Zero page pointer scan stops here

`endif

/* verilog/c64_loader_pkg.sv */
// C64 file loader shared types and loader state encodings
`include "c64_loader_macros.svh"

package c64_loader_pkg;

	// ==============================
	// Vector types
	// ==============================
	typedef logic [7:0]            byte_t;     // Data byte
	typedef logic [`LD_ADDR_W-1:0] mem_addr_t; // System memory address
	typedef logic [15:0]           cpu_addr_t; // 6510 address space
	typedef logic [31:0]           blk_len_t;  // Chip block length
	typedef logic [7:0]            dl_index_t; // Host download index

	// Program injection
	typedef enum logic [1:0] {
		prg_idle,
		prg_header,
		prg_payload,
		prg_zp_rewrite
	} prg_state_e;

	// Cartridge parsing
	typedef enum logic [1:0] {
		crt_file_header,
		crt_chip_header,
		crt_chip_payload
	} crt_state_e;

endpackage

/* verilog/mem_req_if.sv */
// Memory request channel from one loader to the slot scheduler
`timescale 1ns/1ps

interface mem_req_if
	import c64_loader_pkg::*;
();

	logic      req;   // Held with its fields until ack
	logic      we;
	mem_addr_t addr;
	byte_t     wdata;
	logic      ack;   // One-cycle pulse at the end of the granted slot
	byte_t     rdata; // Valid together with ack

	modport master (
		output req, we, addr, wdata,
		input  ack, rdata
	);

	modport slave (
		input  req, we, addr, wdata,
		output ack, rdata
	);

endinterface

/* verilog/prg_injector.sv */
// Program injector writing PRG payload and fixing up the BASIC pointers
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module prg_injector
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      dl_active_i,
	input  dl_index_t dl_index_i,
	input  mem_addr_t dl_addr_i,
	input  logic      dl_wr_i,
	input  byte_t     dl_data_i,
	mem_req_if.master wr,
	output logic      busy_o
);

	localparam cpu_addr_t zp_end = cpu_addr_t'(`LD_ZP_END);

	prg_state_e state;
	cpu_addr_t  load_addr;
	cpu_addr_t  end_addr;
	cpu_addr_t  zp_addr;
	logic       dl_active_d;
	logic       is_prg, prg_wr, pay_wr, zp_step, zp_hit;
	byte_t      zp_val;

	assign is_prg  = (dl_index_i == `LD_IDX_PRG);
	assign prg_wr  = dl_wr_i && dl_active_i && is_prg && (state != prg_zp_rewrite);
	assign pay_wr  = prg_wr && (state == prg_payload); // Past the load address
	assign zp_step = (state == prg_zp_rewrite) && !wr.req && (zp_addr != zp_end);
	assign wr.we   = 1'b1;
	assign busy_o  = wr.req | (state == prg_zp_rewrite);

	// Pointer values as left behind by a BASIC LOAD
	always_comb begin
		zp_hit = 1'b1;
		zp_val = end_addr[7:0];
		case (zp_addr[7:0])
			8'h2b:                      zp_val = 8'h01; // Start of BASIC text
			8'h2c:                      zp_val = 8'h08;
			8'hac, 8'had:               zp_val = 8'h00;
			8'h2d, 8'h2f, 8'h31, 8'hae: zp_val = end_addr[7:0];
			8'h2e, 8'h30, 8'h32, 8'haf: zp_val = end_addr[15:8];
			default:                    zp_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state       <= prg_idle;
			dl_active_d <= 1'b0;
			load_addr   <= '0;
			end_addr    <= '0;
			zp_addr     <= '0;
			wr.req      <= 1'b0;
		end else begin
			dl_active_d <= dl_active_i;
			if (wr.ack) wr.req <= 1'b0;
			case (state)
				prg_idle: if (dl_active_i && is_prg) state <= prg_header;
				prg_header, prg_payload: begin
					if (dl_active_d && !dl_active_i) begin // Download ended
						state   <= prg_zp_rewrite;
						zp_addr <= '0;
					end else if (prg_wr && dl_addr_i == mem_addr_t'(1)) begin
						state <= prg_payload;
					end
				end
				default: if (!wr.req && zp_addr == zp_end) state <= prg_idle;
			endcase
			if (prg_wr && dl_addr_i == '0) begin
				load_addr[7:0] <= dl_data_i;
				end_addr[7:0]  <= dl_data_i;
			end
			if (prg_wr && dl_addr_i == mem_addr_t'(1)) begin
				load_addr[15:8] <= dl_data_i;
				end_addr[15:8]  <= dl_data_i;
			end
			if (pay_wr) begin
				wr.req    <= 1'b1;
				load_addr <= load_addr + 1'b1;
				end_addr  <= end_addr + 1'b1;
			end
			if (zp_step) begin
				zp_addr <= zp_addr + 1'b1; // Untouched bytes are skipped
				if (zp_hit) wr.req <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pay_wr) begin
			wr.addr  <= mem_addr_t'(load_addr);
			wr.wdata <= dl_data_i;
		end else if (zp_step && zp_hit) begin
			wr.addr  <= mem_addr_t'(zp_addr);
			wr.wdata <= zp_val;
		end
	end

endmodule

/* verilog/crt_loader.sv */
// Cartridge loader parsing CRT headers and placing chip data on 8 KB boundaries
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module crt_loader
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      dl_active_i,
	input  dl_index_t dl_index_i,
	input  mem_addr_t dl_addr_i,
	input  logic      dl_wr_i,
	input  byte_t     dl_data_i,
	mem_req_if.master wr,
	output logic      busy_o,
	input  logic      cart_detach_i,
	output cpu_addr_t cart_id_o,
	output byte_t     cart_exrom_o,
	output byte_t     cart_game_o,
	output byte_t     cart_bank_type_o,
	output cpu_addr_t cart_bank_num_o,
	output cpu_addr_t cart_bank_laddr_o,
	output cpu_addr_t cart_bank_size_o,
	output logic      cart_bank_wr_o,
	output logic      cart_attached_o
);

	localparam mem_addr_t align_mask = mem_addr_t'((1 << `LD_CRT_ALIGN_BITS) - 1);

	crt_state_e state;
	mem_addr_t  load_addr;
	blk_len_t   blk_len;   // Payload bytes left in the current chip
	logic [3:0] hdr_cnt;   // Chip header byte index
	logic       dl_active_d;
	logic       is_crt, crt_wr, in_chips, hdr_start, hdr_byte, pay_byte;

	assign is_crt    = (dl_index_i == `LD_IDX_CRT) || (dl_index_i == `LD_IDX_CRT_ALT);
	assign crt_wr    = dl_wr_i && is_crt;
	assign in_chips  = (dl_addr_i >= mem_addr_t'(`LD_CRT_PAYLOAD_START));
	assign hdr_start = crt_wr && in_chips && ((state == crt_file_header) ||
		(state == crt_chip_payload && blk_len == '0));
	assign hdr_byte  = crt_wr && in_chips && (state == crt_chip_header);
	assign pay_byte  = crt_wr && in_chips && (state == crt_chip_payload) && (blk_len != '0);
	assign wr.we     = 1'b1;
	assign busy_o    = wr.req;

	// ==============================
	// Parser control
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state           <= crt_file_header;
			load_addr       <= '0;
			blk_len         <= '0;
			hdr_cnt         <= '0;
			dl_active_d     <= 1'b0;
			wr.req          <= 1'b0;
			cart_bank_wr_o  <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			dl_active_d    <= dl_active_i;
			cart_bank_wr_o <= 1'b0;
			if (wr.ack) wr.req <= 1'b0;
			if (crt_wr && dl_addr_i == '0) begin // New image
				state     <= crt_file_header;
				load_addr <= mem_addr_t'(`LD_CRT_BASE);
				blk_len   <= '0;
				hdr_cnt   <= '0;
			end
			if (hdr_start) begin
				state   <= crt_chip_header;
				hdr_cnt <= 4'd1;
				if ((load_addr & align_mask) != '0) load_addr <= (load_addr | align_mask) + 1'b1;
			end
			if (hdr_byte) begin
				hdr_cnt <= hdr_cnt + 1'b1;
				case (hdr_cnt)
					4'd4:    blk_len[31:24] <= dl_data_i; // Big endian length
					4'd5:    blk_len[23:16] <= dl_data_i;
					4'd6:    blk_len[15:8]  <= dl_data_i;
					4'd7:    blk_len[7:0]   <= dl_data_i;
					4'd8:    blk_len <= blk_len - blk_len_t'(`LD_CRT_CHIP_HDR_LEN);
					4'd15: begin
						cart_bank_wr_o <= 1'b1;
						state          <= crt_chip_payload;
					end
					default: ;
				endcase
			end
			if (pay_byte) begin
				blk_len   <= blk_len - 1'b1;
				load_addr <= load_addr + 1'b1;
				wr.req    <= 1'b1;
			end
			if (cart_detach_i) cart_attached_o <= 1'b0;
			else if (dl_active_d && !dl_active_i && is_crt) cart_attached_o <= 1'b1;
		end
	end

	// Header fields and write payload
	always_ff @(posedge clk_sys) begin
		if (crt_wr) begin
			case (dl_addr_i)
				mem_addr_t'('h16): cart_id_o[15:8] <= dl_data_i;
				mem_addr_t'('h17): cart_id_o[7:0]  <= dl_data_i;
				mem_addr_t'('h18): cart_exrom_o    <= dl_data_i;
				mem_addr_t'('h19): cart_game_o     <= dl_data_i;
				default: ;
			endcase
		end
		if (hdr_byte) begin
			case (hdr_cnt)
				4'd9:  cart_bank_type_o         <= dl_data_i;
				4'd10: cart_bank_num_o[15:8]    <= dl_data_i;
				4'd11: cart_bank_num_o[7:0]     <= dl_data_i;
				4'd12: cart_bank_laddr_o[15:8]  <= dl_data_i;
				4'd13: cart_bank_laddr_o[7:0]   <= dl_data_i;
				4'd14: cart_bank_size_o[15:8]   <= dl_data_i;
				4'd15: cart_bank_size_o[7:0]    <= dl_data_i;
				default: ;
			endcase
		end
		if (pay_byte) begin
			wr.addr  <= load_addr;
			wr.wdata <= dl_data_i;
		end
	end

endmodule

/* verilog/tap_loader.sv */
// Tape loader storing TAP bytes and replaying them in order to the player FIFO
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module tap_loader
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      dl_active_i,
	input  dl_index_t dl_index_i,
	input  mem_addr_t dl_addr_i,
	input  logic      dl_wr_i,
	input  byte_t     dl_data_i,
	input  logic      tape_unload_i,
	input  logic      tape_full_i,
	mem_req_if.master mem,
	output logic      busy_o,
	output byte_t     tape_byte_o,
	output logic      tape_byte_valid_o
);

	localparam mem_addr_t tap_base = mem_addr_t'(`LD_TAP_BASE);

	mem_addr_t play_addr; // Next byte to hand to the player
	mem_addr_t last_addr; // One past the final stored byte
	logic      tape_dl, tap_wr, fetch, rd_ack;

	assign tape_dl = dl_active_i && (dl_index_i == `LD_IDX_TAP);
	assign tap_wr  = dl_wr_i && tape_dl;
	assign fetch   = !mem.req && !tape_dl && !tape_full_i && !tape_unload_i &&
		(play_addr < last_addr);
	assign rd_ack  = mem.ack && !mem.we && (play_addr < last_addr); // Dropped after unload
	assign busy_o  = mem.req;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			mem.req           <= 1'b0;
			play_addr         <= '0;
			last_addr         <= '0;
			tape_byte_valid_o <= 1'b0;
		end else begin
			tape_byte_valid_o <= rd_ack;
			if (mem.ack) mem.req <= 1'b0;
			if (tap_wr || fetch) mem.req <= 1'b1;
			if (tape_unload_i) begin
				play_addr <= '0;
				last_addr <= '0;
			end else begin
				if (tape_dl) play_addr <= '0;
				else if (rd_ack) play_addr <= play_addr + 1'b1;
				if (tap_wr) last_addr <= dl_addr_i + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tap_wr) begin
			mem.we    <= 1'b1;
			mem.addr  <= tap_base + dl_addr_i;
			mem.wdata <= dl_data_i;
		end else if (fetch) begin
			mem.we   <= 1'b0;
			mem.addr <= tap_base + play_addr;
		end
		if (rd_ack) tape_byte_o <= mem.rdata;
	end

endmodule

/* verilog/mem_slot_scheduler.sv */
// Slot scheduler granting loader requests into the core's I/O memory slots
`timescale 1ns/1ps

module mem_slot_scheduler
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      io_cycle_i,
	mem_req_if.slave  prg,
	mem_req_if.slave  crt,
	mem_req_if.slave  tap,
	output logic      mem_ce_o,
	output logic      mem_we_o,
	output mem_addr_t mem_addr_o,
	output byte_t     mem_wdata_o,
	input  byte_t     mem_rdata_i
);

	logic       io_cycle_d;
	logic       slot_open, slot_close;
	logic [2:0] sel;   // One-hot winner among pending requests
	logic [2:0] grant; // Owner of the running slot
	logic       sel_we;
	mem_addr_t  sel_addr;
	byte_t      sel_wdata;
	byte_t      rdata_q;

	assign slot_open  = io_cycle_d & ~io_cycle_i;            // Core hands memory over
	assign slot_close = io_cycle_d & io_cycle_i & mem_ce_o;  // Second high cycle

	// Fixed priority, prg first
	always_comb begin
		sel       = 3'b000;
		sel_we    = tap.we;
		sel_addr  = tap.addr;
		sel_wdata = tap.wdata;
		if (prg.req) begin
			sel       = 3'b001;
			sel_we    = prg.we;
			sel_addr  = prg.addr;
			sel_wdata = prg.wdata;
		end else if (crt.req) begin
			sel       = 3'b010;
			sel_we    = crt.we;
			sel_addr  = crt.addr;
			sel_wdata = crt.wdata;
		end else if (tap.req) begin
			sel = 3'b100;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d <= 1'b0;
			grant      <= 3'b000;
			mem_ce_o   <= 1'b0;
			prg.ack    <= 1'b0;
			crt.ack    <= 1'b0;
			tap.ack    <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			prg.ack    <= 1'b0;
			crt.ack    <= 1'b0;
			tap.ack    <= 1'b0;
			if (slot_open) begin
				grant    <= sel;
				mem_ce_o <= |sel;
			end else if (slot_close) begin
				grant    <= 3'b000;
				mem_ce_o <= 1'b0;
				prg.ack  <= grant[0];
				crt.ack  <= grant[1];
				tap.ack  <= grant[2];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (slot_open) begin
			mem_we_o    <= sel_we;
			mem_addr_o  <= sel_addr;
			mem_wdata_o <= sel_wdata;
		end
		if (slot_close) rdata_q <= mem_rdata_i; // Read data settles by the close
	end

	assign prg.rdata = rdata_q;
	assign crt.rdata = rdata_q;
	assign tap.rdata = rdata_q;

endmodule

/* verilog/c64_loader_top.sv */
// C64 loader top level joining the file loaders to the core memory slots
`timescale 1ns/1ps

module c64_loader_top
	import c64_loader_pkg::*;
(
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  logic                        dl_active_i,
	input  logic [$bits(dl_index_t)-1:0] dl_index_i,
	input  logic [$bits(mem_addr_t)-1:0] dl_addr_i,
	input  logic                        dl_wr_i,
	input  logic [$bits(byte_t)-1:0]     dl_data_i,
	output logic                        dl_wait_o,
	input  logic                        io_cycle_i,
	output logic                        mem_ce_o,
	output logic                        mem_we_o,
	output logic [$bits(mem_addr_t)-1:0] mem_addr_o,
	output logic [$bits(byte_t)-1:0]     mem_wdata_o,
	input  logic [$bits(byte_t)-1:0]     mem_rdata_i,
	input  logic                        cart_detach_i,
	output logic [$bits(cpu_addr_t)-1:0] cart_id_o,
	output logic [$bits(byte_t)-1:0]     cart_exrom_o,
	output logic [$bits(byte_t)-1:0]     cart_game_o,
	output logic [$bits(byte_t)-1:0]     cart_bank_type_o,
	output logic [$bits(cpu_addr_t)-1:0] cart_bank_num_o,
	output logic [$bits(cpu_addr_t)-1:0] cart_bank_laddr_o,
	output logic [$bits(cpu_addr_t)-1:0] cart_bank_size_o,
	output logic                        cart_bank_wr_o,
	output logic                        cart_attached_o,
	input  logic                        tape_unload_i,
	input  logic                        tape_full_i,
	output logic [$bits(byte_t)-1:0]     tape_byte_o,
	output logic                        tape_byte_valid_o
);

	mem_req_if prg_if ();
	mem_req_if crt_if ();
	mem_req_if tap_if ();

	logic prg_busy, crt_busy, tap_busy;

	assign dl_wait_o = prg_busy | crt_busy | tap_busy; // Host holds off while any loader waits

	prg_injector i_prg_injector (
		.*,
		.wr     (prg_if),
		.busy_o (prg_busy)
	);

	crt_loader i_crt_loader (
		.*,
		.wr     (crt_if),
		.busy_o (crt_busy)
	);

	tap_loader i_tap_loader (
		.*,
		.mem    (tap_if),
		.busy_o (tap_busy)
	);

	mem_slot_scheduler i_mem_slot_scheduler (
		.*,
		.prg (prg_if),
		.crt (crt_if),
		.tap (tap_if)
	);

endmodule

/* dv/c64_loader_tb.sv */
// Loader testbench driving PRG, CRT and TAP downloads against a slot and memory model
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module c64_loader_tb
	import c64_loader_pkg::*;
();

	localparam int KIND_PRG = 0;
	localparam int KIND_CRT = 1;
	localparam int KIND_TAP = 2;
	localparam int N_TESTS  = 5;
	localparam int TIMEOUT  = 2000; // Cycles allowed for any single wait

	logic      clk_sys = 1'b0;
	logic      reset_n;
	logic      dl_active_i, dl_wr_i, dl_wait_o;
	dl_index_t dl_index_i;
	mem_addr_t dl_addr_i, mem_addr_o;
	byte_t     dl_data_i, mem_wdata_o, mem_rdata_i;
	logic      io_cycle_i, mem_ce_o, mem_we_o;
	logic      cart_detach_i, cart_bank_wr_o, cart_attached_o;
	cpu_addr_t cart_id_o, cart_bank_num_o, cart_bank_laddr_o, cart_bank_size_o;
	byte_t     cart_exrom_o, cart_game_o, cart_bank_type_o, tape_byte_o;
	logic      tape_unload_i, tape_full_i, tape_byte_valid_o;

	// ==============================
	// Test table
	// ==============================
	int        tbl_kind  [N_TESTS] = '{KIND_PRG, KIND_CRT, KIND_CRT, KIND_TAP, KIND_TAP};
	dl_index_t tbl_index [N_TESTS] = '{`LD_IDX_PRG, `LD_IDX_CRT, `LD_IDX_CRT_ALT,
		`LD_IDX_TAP, `LD_IDX_TAP};
	int        tbl_len   [N_TESTS] = '{8, 6, 3, 10, 12}; // Payload bytes, per chip for CRT
	int        tbl_chips [N_TESTS] = '{0, 2, 3, 0, 0};
	int        tbl_mode  [N_TESTS] = '{0, 0, 0, 1, 2};   // 1 holds tape_full_i, 2 unloads
	string     kind_name [3]       = '{"PRG", "CRT", "TAP"};

	byte_t       mem_model [int]; // Only bytes written by the DUT
	byte_t       file_q [$];
	int          exp_addr [$];
	byte_t       exp_val [$];
	byte_t       tape_q [$];
	logic [55:0] bank_q [$];     // type, number, load address, size
	logic [55:0] exp_bank [$];
	cpu_addr_t   exp_id;
	byte_t       exp_exrom, exp_game;
	logic [31:0] rng = 32'h8fbe0d0a;
	int          io_cnt = 0;
	int          test_errors, errors, passed, failed;

	c64_loader_top i_c64_loader_top (.*);

	always #50 clk_sys = ~clk_sys;

	// ==============================
	// Core slot and memory model
	// ==============================
	function automatic byte_t fill_byte(input int a);
		return 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16) ^ 8'(a >> 24) ^ 8'h3c;
	endfunction

	function automatic byte_t mem_read(input int a);
		if (mem_model.exists(a)) return mem_model[a];
		return fill_byte(a); // Preloaded contents
	endfunction

	always @(negedge clk_sys) begin
		io_cnt     = (io_cnt + 1) % 16;
		io_cycle_i = (io_cnt < 4); // 4 high, 12 low
		if (mem_ce_o && mem_we_o) mem_model[int'(mem_addr_o)] = mem_wdata_o;
		else if (mem_ce_o) mem_rdata_i = mem_read(int'(mem_addr_o));
		if (tape_byte_valid_o) tape_q.push_back(tape_byte_o);
		if (cart_bank_wr_o) begin
			bank_q.push_back({cart_bank_type_o, cart_bank_num_o, cart_bank_laddr_o,
				cart_bank_size_o});
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic rand_byte(output byte_t b);
		rng = xorshift32(rng);
		b   = rng[7:0];
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		test_errors++;
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Error %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	// ==============================
	// Host download side
	// ==============================
	task automatic wait_dl_idle(input string what);
		int t;
		t = 0;
		while (dl_wait_o && t < TIMEOUT) begin
			@(negedge clk_sys);
			t++;
		end
		assert (!dl_wait_o) else
			report_failure($sformatf("dl_wait_o stuck high during %s", what));
	endtask

	task automatic send_byte(input int addr, input byte_t data);
		dl_addr_i = mem_addr_t'(addr);
		dl_data_i = data;
		dl_wr_i   = 1'b1;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		@(negedge clk_sys);
		wait_dl_idle("a byte write");
	endtask

	task automatic send_file(input dl_index_t index);
		@(negedge clk_sys);
		dl_index_i  = index;
		dl_active_i = 1'b1;
		@(negedge clk_sys);
		foreach (file_q[i]) send_byte(i, file_q[i]);
		dl_active_i = 1'b0; // Index stays put so the end is seen by the right loader
		@(negedge clk_sys);
		wait_dl_idle("the end of the download");
	endtask

	task automatic wait_tape_count(input int n);
		int t;
		t = 0;
		while (tape_q.size() < n && t < TIMEOUT) begin
			@(posedge clk_sys);
			t++;
		end
		assert (tape_q.size() >= n) else
			report_failure($sformatf("Only %0d of %0d tape bytes arrived", tape_q.size(), n));
	endtask

	// ==============================
	// File images and expectations
	// ==============================
	function automatic byte_t zp_expected(input int a, input cpu_addr_t end_addr);
		case (a)
			'h2b:                   return 8'h01;
			'h2c:                   return 8'h08;
			'hac, 'had:             return 8'h00;
			'h2d, 'h2f, 'h31, 'hae: return end_addr[7:0];
			'h2e, 'h30, 'h32, 'haf: return end_addr[15:8];
			default:                return fill_byte(a);
		endcase
	endfunction

	task automatic prg_image(input int n);
		byte_t b;
		file_q.push_back(8'h01); // Load address C001, low byte first
		file_q.push_back(8'hc0);
		for (int j = 0; j < n; j++) begin
			rand_byte(b);
			file_q.push_back(b);
			exp_addr.push_back('hc001 + j);
			exp_val.push_back(b);
		end
		for (int a = 0; a < `LD_ZP_END; a++) begin
			exp_addr.push_back(a);
			exp_val.push_back(zp_expected(a, cpu_addr_t'('hc001 + n)));
		end
	endtask

	task automatic crt_image(input int n, input int chips);
		byte_t       b, chip_type;
		byte_t       hdr [16];
		logic [31:0] len;
		cpu_addr_t   laddr;
		for (int a = 0; a < `LD_CRT_PAYLOAD_START; a++) begin
			rand_byte(b);
			file_q.push_back(b);
		end
		exp_id    = {file_q['h16], file_q['h17]};
		exp_exrom = file_q['h18];
		exp_game  = file_q['h19];
		for (int k = 0; k < chips; k++) begin
			rand_byte(chip_type);
			len   = 32'(n + `LD_CRT_CHIP_HDR_LEN);
			laddr = 16'h8000 + 16'(k << 13);
			hdr   = '{8'h43, 8'h48, 8'h49, 8'h50,
				len[31:24], len[23:16], len[15:8], len[7:0],
				8'h00, chip_type, 8'h00, 8'(k), laddr[15:8], laddr[7:0], 8'(n >> 8), 8'(n)};
			foreach (hdr[h]) file_q.push_back(hdr[h]);
			exp_bank.push_back({chip_type, 16'(k), laddr, 16'(n)});
			for (int j = 0; j < n; j++) begin
				rand_byte(b);
				file_q.push_back(b);
				exp_addr.push_back(int'(`LD_CRT_BASE + (k << `LD_CRT_ALIGN_BITS) + j));
				exp_val.push_back(b);
			end
		end
	endtask

	task automatic tap_image(input int n);
		byte_t b;
		for (int j = 0; j < n; j++) begin
			rand_byte(b);
			file_q.push_back(b);
			exp_addr.push_back(int'(`LD_TAP_BASE + j));
			exp_val.push_back(b);
		end
	endtask

	// ==============================
	// Checks
	// ==============================
	task automatic verify_memory();
		foreach (exp_addr[j]) begin
			compare_value($sformatf("mem[%h]", exp_addr[j]), 64'(mem_read(exp_addr[j])),
				64'(exp_val[j]));
		end
	endtask

	task automatic verify_cartridge();
		compare_value("cart_id_o", 64'(cart_id_o), 64'(exp_id));
		compare_value("cart_exrom_o", 64'(cart_exrom_o), 64'(exp_exrom));
		compare_value("cart_game_o", 64'(cart_game_o), 64'(exp_game));
		assert (bank_q.size() == exp_bank.size()) else report_failure($sformatf(
			"Expected %0d cart_bank_wr_o pulses, saw %0d", exp_bank.size(), bank_q.size()));
		foreach (bank_q[k]) begin
			if (k < exp_bank.size()) begin
				compare_value($sformatf("bank descriptor %0d", k), 64'(bank_q[k]),
					64'(exp_bank[k]));
			end
		end
		assert (cart_attached_o) else
			report_failure("cart_attached_o did not rise after the download");
		@(negedge clk_sys);
		cart_detach_i = 1'b1;
		@(negedge clk_sys);
		cart_detach_i = 1'b0;
		assert (!cart_attached_o) else
			report_failure("cart_attached_o stayed high after detach");
	endtask

	task automatic verify_playback(input int mode, input int n);
		int raised, held;
		if (mode == 1) begin
			wait_tape_count(3);
			@(negedge clk_sys);
			tape_full_i = 1'b1;
			@(posedge clk_sys);
			raised = tape_q.size();
			repeat (40) @(posedge clk_sys); // A read already granted may still land
			held = tape_q.size();
			assert (held <= raised + 1) else
				report_failure("Tape fetches went on after tape_full_i rose");
			repeat (200) @(posedge clk_sys);
			assert (tape_q.size() == held) else
				report_failure("Tape bytes arrived while tape_full_i was high");
			@(negedge clk_sys);
			tape_full_i = 1'b0;
		end
		if (mode == 2) begin
			wait_tape_count(2);
			@(negedge clk_sys);
			tape_unload_i = 1'b1;
			@(negedge clk_sys);
			tape_unload_i = 1'b0;
			@(posedge clk_sys);
			held = tape_q.size();
			repeat (300) @(posedge clk_sys);
			assert (tape_q.size() == held) else
				report_failure("Tape byte delivered after tape_unload_i");
			assert (held < n) else
				report_failure("Playback ended before tape_unload_i was applied");
		end else begin
			wait_tape_count(n);
			repeat (100) @(posedge clk_sys);
			assert (tape_q.size() == n) else
				report_failure($sformatf("Expected %0d tape bytes, saw %0d", n, tape_q.size()));
		end
		foreach (tape_q[j]) begin
			if (j < exp_val.size()) begin
				compare_value($sformatf("tape_byte_o #%0d", j), 64'(tape_q[j]),
					64'(exp_val[j]));
			end
		end
	endtask

	task automatic end_test(input string name);
		errors += test_errors;
		if (test_errors == 0) passed++;
		else failed++;
		$display("Test %s: %s (%0d errors)", name,
			(test_errors == 0) ? "ok" : "FAILED", test_errors);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		reset_n       = 1'b0;
		dl_active_i   = 1'b0;
		dl_index_i    = '0;
		dl_addr_i     = '0;
		dl_wr_i       = 1'b0;
		dl_data_i     = '0;
		io_cycle_i    = 1'b0;
		mem_rdata_i   = '0;
		cart_detach_i = 1'b0;
		tape_unload_i = 1'b0;
		tape_full_i   = 1'b0;
		errors        = 0;
		passed        = 0;
		failed        = 0;
		repeat (2) @(negedge clk_sys);
		reset_n     = 1'b1;
		test_errors = 0;
		assert (!mem_ce_o && !dl_wait_o && !cart_bank_wr_o && !tape_byte_valid_o &&
			!cart_attached_o) else report_failure("An output was not low after reset");
		end_test("reset");

		for (int i = 0; i < N_TESTS; i++) begin
			test_errors = 0;
			file_q.delete();
			exp_addr.delete();
			exp_val.delete();
			exp_bank.delete();
			case (tbl_kind[i])
				KIND_PRG: prg_image(tbl_len[i]);
				KIND_CRT: crt_image(tbl_len[i], tbl_chips[i]);
				default:  tap_image(tbl_len[i]);
			endcase
			tape_q.delete();
			bank_q.delete();
			send_file(tbl_index[i]);
			if (tbl_kind[i] == KIND_CRT) verify_cartridge();
			if (tbl_kind[i] == KIND_TAP) verify_playback(tbl_mode[i], tbl_len[i]);
			verify_memory();
			end_test($sformatf("%0d %s, %0d bytes", i, kind_name[tbl_kind[i]], tbl_len[i]));
		end

		$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
		if (failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
verilog/c64_loader_pkg.sv
verilog/mem_req_if.sv
verilog/prg_injector.sv
verilog/crt_loader.sv
verilog/tap_loader.sv
verilog/mem_slot_scheduler.sv
verilog/c64_loader_top.sv
dv/c64_loader_tb.sv

/* run.sh */
#!/bin/sh
# Build the loader testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module c64_loader_tb \
	-f filelist.f -o c64_loader_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/c64_loader_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "$out" | grep -qF 'All tests passed!' || exit 1
exit 0
